// ==== Bender.yml ====
package:
  name: rename_core

sources:
  - include_dirs:
      - .
    files:
      - rob_pkg.sv
      - cdb_if.sv
      - exec_unit.sv
      - cdb_arbiter.sv
      - reorder_buffer.sv
      - arch_map_table.sv
      - rename_core_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_rename_core.sv

// ==== arch_map_table.sv ====
/*
 * Committed register map, written at retire.
 * Resets to the identity map, register r to tag r.
 * Same register in both slots: the younger slot wins.
 */
`timescale 1ns/1ps
`include "rob_defines.svh"

module arch_map_table (
    input  logic                                 clk_i,
    input  logic                                 reset_i,
    input  logic [`RT_WIDTH-1:0]                 rt_valid_i,
    input  rob_pkg::arch_idx_t [`RT_WIDTH-1:0]   rt_arch_reg_i,
    input  rob_pkg::tag_t [`RT_WIDTH-1:0]        rt_tag_i,
    input  rob_pkg::arch_idx_t                   rd_arch_i,
    output rob_pkg::tag_t                        rd_tag_o
);
    import rob_pkg::*;

    tag_t map_q [`ARCH_REG_NUM];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int r = 0; r < `ARCH_REG_NUM; r++) begin
                map_q[r] <= tag_t'(r);
            end
        end else begin
            // Later slot assigned last, so it overrides
            for (int s = 0; s < `RT_WIDTH; s++) begin
                if (rt_valid_i[s]) map_q[rt_arch_reg_i[s]] <= rt_tag_i[s];
            end
        end
    end

    assign rd_tag_o = map_q[rd_arch_i];   // Combinational read

endmodule

// ==== cdb_arbiter.sv ====
/*
 * Round-robin CDB arbiter, one grant per cycle, decided combinationally.
 * After unit k wins, the next unit in order has priority.
 */
`timescale 1ns/1ps
`include "rob_defines.svh"

module cdb_arbiter (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic [`EU_NUM-1:0]    eu_req_i,
    input  rob_pkg::tag_t         res_tag_i [`EU_NUM],
    input  rob_pkg::rob_idx_t     res_rob_idx_i [`EU_NUM],
    input  logic                  res_mispredict_i [`EU_NUM],
    output logic [`EU_NUM-1:0]    eu_gnt_o,
    cdb_if.source                 cdb
);
    localparam int SEL_W = (`EU_NUM > 1) ? $clog2(`EU_NUM) : 1;

    logic [SEL_W-1:0] prio_q;       // Unit searched first
    logic [SEL_W-1:0] gnt_idx;
    logic             gnt_any;

    always_comb begin
        int idx;
        gnt_any  = 1'b0;
        gnt_idx  = '0;
        eu_gnt_o = '0;
        for (int i = 0; i < `EU_NUM; i++) begin
            idx = (int'(prio_q) + i) % `EU_NUM;     // Rotate from the pointer
            if (!gnt_any && eu_req_i[idx]) begin
                gnt_any = 1'b1;
                gnt_idx = SEL_W'(idx);
            end
        end
        eu_gnt_o[gnt_idx] = gnt_any;
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            prio_q <= '0;
        end else if (gnt_any) begin
            prio_q <= (gnt_idx == SEL_W'(`EU_NUM - 1)) ? '0 : gnt_idx + 1'b1;
        end
    end

    // Winner drives the bus
    assign cdb.valid      = gnt_any;
    assign cdb.tag        = res_tag_i[gnt_idx];
    assign cdb.rob_idx    = res_rob_idx_i[gnt_idx];
    assign cdb.mispredict = res_mispredict_i[gnt_idx];

    // All units waiting: exactly one wins and the winner moves on
    a_gnt_rotate: assert property (@(posedge clk_i) disable iff (reset_i)
        (&eu_req_i && $past(&eu_req_i)) |-> ($onehot(eu_gnt_o) && eu_gnt_o != $past(eu_gnt_o)))
        else $error("CDB grant not rotating between waiting units");

endmodule

// ==== cdb_if.sv ====
/*
 * One result broadcast per cycle, valid for a single cycle.
 * No back-pressure on the bus.
 */
`timescale 1ns/1ps

interface cdb_if;
    import rob_pkg::*;

    logic     valid;        // Broadcast strobe
    tag_t     tag;          // Physical tag of the result
    rob_idx_t rob_idx;      // Entry to mark complete
    logic     mispredict;   // Branch resolved wrong

    modport source (
        output valid, tag, rob_idx, mispredict
    );

    modport sink (
        input valid, tag, rob_idx, mispredict
    );
endinterface

// ==== exec_unit.sv ====
/*
 * Fixed-latency unit. One issue per cycle, LATENCY >= 1.
 * Finished results wait in a queue until granted the CDB.
 * Queue depth equals the ROB size, so it cannot fill in normal use.
 */
`timescale 1ns/1ps
`include "rob_defines.svh"

module exec_unit #(
    parameter int LATENCY = 1
) (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              flush_i,            // Drop everything in flight
    input  logic              issue_valid_i,
    input  rob_pkg::tag_t     issue_tag_i,
    input  rob_pkg::rob_idx_t issue_rob_idx_i,
    input  logic              issue_mispredict_i,
    output logic              eu_req_o,           // Queue not empty
    input  logic              eu_gnt_i,           // Pop front at next edge
    output rob_pkg::tag_t     res_tag_o,
    output rob_pkg::rob_idx_t res_rob_idx_o,
    output logic              res_mispredict_o
);
    import rob_pkg::*;

    localparam int DEPTH = `ROB_ENTRY_NUM;
    localparam int PTR_W = $clog2(DEPTH);

    typedef struct packed {
        tag_t     tag;
        rob_idx_t rob_idx;
        logic     mispredict;
    } res_t;

    logic [LATENCY-1:0] pipe_vld_q;     // Stage valids
    res_t               pipe_q [LATENCY];
    res_t               q_mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr_q, rd_ptr_q;
    logic [PTR_W:0]     cnt_q;
    logic               push, pop;

    ////////////////////
    // Latency pipeline
    ////////////////////
    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            pipe_vld_q <= '0;
        end else begin
            pipe_vld_q[0] <= issue_valid_i;
            for (int i = 1; i < LATENCY; i++) begin
                pipe_vld_q[i] <= pipe_vld_q[i-1];
            end
        end
    end

    always_ff @(posedge clk_i) begin   // Payload follows the valids
        pipe_q[0] <= '{issue_tag_i, issue_rob_idx_i, issue_mispredict_i};
        for (int i = 1; i < LATENCY; i++) begin
            pipe_q[i] <= pipe_q[i-1];
        end
    end

    ////////////////////
    // Result queue
    ////////////////////
    assign push     = pipe_vld_q[LATENCY-1];
    assign eu_req_o = (cnt_q != '0);
    assign pop      = eu_gnt_i && eu_req_o;

    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
            cnt_q <= cnt_q + push - pop;   // Push and pop may coincide
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) q_mem[wr_ptr_q] <= pipe_q[LATENCY-1];
    end

    // Front of queue
    assign res_tag_o        = q_mem[rd_ptr_q].tag;
    assign res_rob_idx_o    = q_mem[rd_ptr_q].rob_idx;
    assign res_mispredict_o = q_mem[rd_ptr_q].mispredict;

    // More in flight than the ROB can hold would wrap the queue
    a_no_overflow: assert property (@(posedge clk_i) disable iff (reset_i || flush_i)
        (push && !pop) |-> (cnt_q < DEPTH))
        else $error("exec_unit result queue overflow");

endmodule

// ==== list.f ====
+incdir+.
rob_pkg.sv
cdb_if.sv
exec_unit.sv
cdb_arbiter.sv
reorder_buffer.sv
arch_map_table.sv
rename_core_top.sv
tb_rename_core.sv

// ==== rename_core_top.sv ====
/*
 * Retire half of the core: two units, CDB arbiter, ROB, map table.
 * Both dispatch slots must not pick the same unit in one cycle.
 */
`timescale 1ns/1ps
`include "rob_defines.svh"

module rename_core_top (
    input  logic                                 clk_i,
    input  logic                                 reset_i,
    input  logic [`DP_WIDTH-1:0]                 dp_valid_i,
    input  rob_pkg::eu_sel_e [`DP_WIDTH-1:0]     dp_unit_i,
    input  rob_pkg::arch_idx_t [`DP_WIDTH-1:0]   dp_arch_reg_i,
    input  rob_pkg::tag_t [`DP_WIDTH-1:0]        dp_tag_i,
    input  rob_pkg::tag_t [`DP_WIDTH-1:0]        dp_tag_old_i,
    input  logic [`DP_WIDTH-1:0]                 dp_is_branch_i,
    input  logic [`DP_WIDTH-1:0]                 dp_mispredict_i,   // Carried to the CDB
    output logic [`DP_WIDTH-1:0]                 dp_ready_o,
    output logic [`RT_WIDTH-1:0]                 rt_valid_o,
    output rob_pkg::arch_idx_t [`RT_WIDTH-1:0]   rt_arch_reg_o,
    output rob_pkg::tag_t [`RT_WIDTH-1:0]        rt_tag_o,
    output rob_pkg::tag_t [`RT_WIDTH-1:0]        rt_tag_old_o,
    output logic                                 flush_o,
    input  rob_pkg::arch_idx_t                   amt_rd_arch_i,
    output rob_pkg::tag_t                        amt_rd_tag_o
);
    import rob_pkg::*;

    rob_idx_t [`DP_WIDTH-1:0] dp_rob_idx;
    logic [`EU_NUM-1:0]       eu_req, eu_gnt;
    tag_t                     eu_res_tag [`EU_NUM];
    rob_idx_t                 eu_res_rob_idx [`EU_NUM];
    logic                     eu_res_mispredict [`EU_NUM];

    cdb_if cdb ();

    ////////////////////
    // Units
    ////////////////////
    for (genvar u = 0; u < `EU_NUM; u++) begin : g_eu
        logic     issue_valid;
        tag_t     issue_tag;
        rob_idx_t issue_rob_idx;
        logic     issue_mispredict;

        // Pick the accepted slot that names this unit
        always_comb begin
            issue_valid      = 1'b0;
            issue_tag        = '0;
            issue_rob_idx    = '0;
            issue_mispredict = 1'b0;
            for (int s = 0; s < `DP_WIDTH; s++) begin
                if (dp_valid_i[s] && dp_ready_o[s] && dp_unit_i[s] == eu_sel_e'(u)) begin
                    issue_valid      = 1'b1;
                    issue_tag        = dp_tag_i[s];
                    issue_rob_idx    = dp_rob_idx[s];
                    issue_mispredict = dp_mispredict_i[s];
                end
            end
        end

        exec_unit #(
            .LATENCY ((u == 0) ? `EU0_LATENCY : `EU1_LATENCY)
        ) u_eu (
            .clk_i              (clk_i),
            .reset_i            (reset_i),
            .flush_i            (flush_o),
            .issue_valid_i      (issue_valid),
            .issue_tag_i        (issue_tag),
            .issue_rob_idx_i    (issue_rob_idx),
            .issue_mispredict_i (issue_mispredict),
            .eu_req_o           (eu_req[u]),
            .eu_gnt_i           (eu_gnt[u]),
            .res_tag_o          (eu_res_tag[u]),
            .res_rob_idx_o      (eu_res_rob_idx[u]),
            .res_mispredict_o   (eu_res_mispredict[u])
        );
    end

    cdb_arbiter u_arb (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .eu_req_i         (eu_req),
        .res_tag_i        (eu_res_tag),
        .res_rob_idx_i    (eu_res_rob_idx),
        .res_mispredict_i (eu_res_mispredict),
        .eu_gnt_o         (eu_gnt),
        .cdb              (cdb)
    );

    reorder_buffer u_rob (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .dp_valid_i     (dp_valid_i),
        .dp_arch_reg_i  (dp_arch_reg_i),
        .dp_tag_i       (dp_tag_i),
        .dp_tag_old_i   (dp_tag_old_i),
        .dp_is_branch_i (dp_is_branch_i),
        .dp_ready_o     (dp_ready_o),
        .dp_rob_idx_o   (dp_rob_idx),
        .cdb            (cdb),
        .rt_valid_o     (rt_valid_o),
        .rt_arch_reg_o  (rt_arch_reg_o),
        .rt_tag_o       (rt_tag_o),
        .rt_tag_old_o   (rt_tag_old_o),
        .flush_o        (flush_o)
    );

    arch_map_table u_amt (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .rt_valid_i    (rt_valid_o),
        .rt_arch_reg_i (rt_arch_reg_o),
        .rt_tag_i      (rt_tag_o),
        .rd_arch_i     (amt_rd_arch_i),
        .rd_tag_o      (amt_rd_tag_o)
    );

    // One issue port per unit per cycle
    a_unit_conflict: assert property (@(posedge clk_i) disable iff (reset_i)
        (&(dp_valid_i & dp_ready_o)) |-> (dp_unit_i[0] != dp_unit_i[1]))
        else $error("Both dispatch slots sent to one unit");

endmodule

// ==== reorder_buffer.sv ====
/*
 * Circular reorder buffer. Head and tail carry a wrap bit.
 * Retire is combinational from head, up to RT_WIDTH in order.
 * A retiring mispredicted branch empties the buffer at the next edge.
 */
`timescale 1ns/1ps
`include "rob_defines.svh"

module reorder_buffer (
    input  logic                                     clk_i,
    input  logic                                     reset_i,
    // Dispatch
    input  logic [`DP_WIDTH-1:0]                     dp_valid_i,
    input  rob_pkg::arch_idx_t [`DP_WIDTH-1:0]       dp_arch_reg_i,
    input  rob_pkg::tag_t [`DP_WIDTH-1:0]            dp_tag_i,
    input  rob_pkg::tag_t [`DP_WIDTH-1:0]            dp_tag_old_i,
    input  logic [`DP_WIDTH-1:0]                     dp_is_branch_i,
    output logic [`DP_WIDTH-1:0]                     dp_ready_o,
    output rob_pkg::rob_idx_t [`DP_WIDTH-1:0]        dp_rob_idx_o,   // Entry per slot
    // Complete
    cdb_if.sink                                      cdb,
    // Retire
    output logic [`RT_WIDTH-1:0]                     rt_valid_o,
    output rob_pkg::arch_idx_t [`RT_WIDTH-1:0]       rt_arch_reg_o,
    output rob_pkg::tag_t [`RT_WIDTH-1:0]            rt_tag_o,
    output rob_pkg::tag_t [`RT_WIDTH-1:0]            rt_tag_old_o,
    output logic                                     flush_o
);
    import rob_pkg::*;

    localparam int CNT_W = $bits(rob_ptr_t);

    rob_entry_t                     rob_q [`ROB_ENTRY_NUM];
    rob_ptr_t                       head_q, tail_q;
    rob_state_e                     state_q;
    logic [CNT_W-1:0]               used, avail;
    logic [`DP_WIDTH-1:0]           dp_take;
    logic [$clog2(`DP_WIDTH+1)-1:0] dp_cnt;
    logic [$clog2(`RT_WIDTH+1)-1:0] rt_cnt;
    rob_idx_t [`RT_WIDTH-1:0]       rt_idx;

    ////////////////////
    // Occupancy, ready
    ////////////////////
    assign used  = tail_q - head_q;                     // Wrap bit makes 16 distinct from 0
    assign avail = CNT_W'(`ROB_ENTRY_NUM) - used;

    always_comb begin
        for (int s = 0; s < `DP_WIDTH; s++) begin
            dp_ready_o[s] = (avail > s) && !flush_o;     // Lower slots first
        end
    end

    assign dp_take = dp_valid_i & dp_ready_o;

    // Slot 0 is older, so it gets the lower index
    always_comb begin
        rob_idx_t nxt;
        nxt    = rob_idx_t'(tail_q);
        dp_cnt = '0;
        for (int s = 0; s < `DP_WIDTH; s++) begin
            dp_rob_idx_o[s] = nxt;
            if (dp_take[s]) begin
                nxt    = nxt + 1'b1;
                dp_cnt = dp_cnt + 1'b1;
            end
        end
    end

    ////////////////////
    // Retire chain
    ////////////////////
    always_comb begin
        logic go;
        go      = (state_q == RUN);
        flush_o = 1'b0;
        rt_cnt  = '0;
        for (int s = 0; s < `RT_WIDTH; s++) begin
            rt_idx[s]        = rob_idx_t'(head_q + CNT_W'(s));
            rt_valid_o[s]    = go && rob_q[rt_idx[s]].valid && rob_q[rt_idx[s]].complete;
            rt_arch_reg_o[s] = rob_q[rt_idx[s]].arch_reg;
            rt_tag_o[s]      = rob_q[rt_idx[s]].tag;
            rt_tag_old_o[s]  = rob_q[rt_idx[s]].tag_old;
            if (rt_valid_o[s]) begin
                rt_cnt = rt_cnt + 1'b1;
                if (rob_q[rt_idx[s]].is_branch && rob_q[rt_idx[s]].mispredict) begin
                    flush_o = 1'b1;     // Retires, but nothing younger does
                end
            end
            // Stop at first incomplete entry or after a bad branch
            go = rt_valid_o[s] && !(rob_q[rt_idx[s]].is_branch && rob_q[rt_idx[s]].mispredict);
        end
    end

    ////////////////////
    // Pointers, state
    ////////////////////
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            state_q <= RUN;
        end else if (flush_o) begin
            head_q  <= '0;          // Empty, younger work discarded
            tail_q  <= '0;
            state_q <= FLUSH;
        end else begin
            head_q  <= head_q + CNT_W'(rt_cnt);
            tail_q  <= tail_q + CNT_W'(dp_cnt);
            state_q <= RUN;
        end
    end

    // Entries: valid is control, the rest is payload
    always_ff @(posedge clk_i) begin
        if (reset_i || flush_o) begin
            for (int i = 0; i < `ROB_ENTRY_NUM; i++) begin
                rob_q[i].valid <= 1'b0;
            end
        end else begin
            for (int s = 0; s < `RT_WIDTH; s++) begin
                if (rt_valid_o[s]) rob_q[rt_idx[s]].valid <= 1'b0;
            end
            if (cdb.valid) begin
                rob_q[cdb.rob_idx].complete   <= 1'b1;
                rob_q[cdb.rob_idx].mispredict <= cdb.mispredict;
            end
            for (int s = 0; s < `DP_WIDTH; s++) begin
                if (dp_take[s]) begin
                    rob_q[dp_rob_idx_o[s]] <= '{valid: 1'b1, arch_reg: dp_arch_reg_i[s],
                        tag: dp_tag_i[s], tag_old: dp_tag_old_i[s], complete: 1'b0,
                        is_branch: dp_is_branch_i[s], mispredict: 1'b0};
                end
            end
        end
    end

    ////////////////////
    // Checks
    ////////////////////
    // Result must land on a live entry holding the same tag
    a_cdb_live: assert property (@(posedge clk_i) disable iff (reset_i)
        cdb.valid |-> (rob_q[cdb.rob_idx].valid && rob_q[cdb.rob_idx].tag == cdb.tag))
        else $error("CDB broadcast to an invalid entry");

    // Dispatch only into entries that retire or flush has freed
    for (genvar s = 0; s < `DP_WIDTH; s++) begin : g_dp_chk
        a_dp_free: assert property (@(posedge clk_i) disable iff (reset_i)
            dp_take[s] |-> !rob_q[dp_rob_idx_o[s]].valid)
            else $error("Dispatch into a live ROB entry");
    end

    // Units were emptied together with the buffer
    a_flush_quiet: assert property (@(posedge clk_i) disable iff (reset_i)
        (state_q == FLUSH) |-> !cdb.valid)
        else $error("CDB active right after flush");

endmodule

// ==== rob_defines.svh ====
/*
 * Sizes for the retire side of the core.
 * Unit latencies must be at least 1 cycle.
 * EU_NUM is fixed at 2 by the dispatch routing in the top level.
 */
`ifndef ROB_DEFINES_SVH
`define ROB_DEFINES_SVH

////////////////////
// Widths
////////////////////
`define DP_WIDTH        2   // Dispatch slots per cycle
`define RT_WIDTH        2   // Retire slots per cycle
`define ROB_ENTRY_NUM   16  // Reorder buffer depth, power of 2
`define ARCH_REG_NUM    32  // Architectural registers
`define PHY_REG_NUM     64  // Physical registers (tag space)

////////////////////
// Execution units
////////////////////
`define EU_NUM          2   // Units sharing the CDB
`define EU0_LATENCY     1   // Fast unit
`define EU1_LATENCY     4   // Slow unit

`endif

// ==== rob_pkg.sv ====
/*
 * Shared types for the reorder buffer, units and map table.
 * Index widths follow the sizes in rob_defines.svh.
 */
`include "rob_defines.svh"

package rob_pkg;

    ////////////////////
    // Index types
    ////////////////////
    typedef logic [$clog2(`ARCH_REG_NUM)-1:0]  arch_idx_t;
    typedef logic [$clog2(`PHY_REG_NUM)-1:0]   tag_t;
    typedef logic [$clog2(`ROB_ENTRY_NUM)-1:0] rob_idx_t;
    typedef logic [$clog2(`ROB_ENTRY_NUM):0]   rob_ptr_t;   // MSB is the wrap bit

    // One reorder buffer slot
    typedef struct packed {
        logic      valid;
        arch_idx_t arch_reg;    // Destination register
        tag_t      tag;         // New physical tag
        tag_t      tag_old;     // Tag released at retire
        logic      complete;    // Set from the CDB
        logic      is_branch;
        logic      mispredict;  // Only meaningful on branches
    } rob_entry_t;

    ////////////////////
    // Enums
    ////////////////////
    typedef enum logic {
        RUN,
        FLUSH   // One cycle after a mispredict retire
    } rob_state_e;

    typedef enum logic {
        EU_FAST,    // Unit 0
        EU_SLOW     // Unit 1
    } eu_sel_e;

endpackage

// ==== tb_rename_core.sv ====
/*
 * Testbench for rename_core_top. Acts as the front end and supplies tags.
 * Completion timing is not modelled, only program order, ready and map state.
 * The run is bounded by a cycle counter.
 */
`timescale 1ns/1ps
`include "rob_defines.svh"

module tb_rename_core;
    import rob_pkg::*;

    localparam int CYCLE_LIMIT = 4000;  // Five tests, each well under 300 cycles
    localparam int FILL_LIMIT  = 200;

    typedef struct {
        arch_idx_t arch;
        tag_t      tag;
        tag_t      tag_old;
        logic      is_branch;
        logic      mispredict;
    } instr_t;

    logic                             clk;
    logic                             reset;
    logic [`DP_WIDTH-1:0]             dp_valid;
    eu_sel_e [`DP_WIDTH-1:0]          dp_unit;
    arch_idx_t [`DP_WIDTH-1:0]        dp_arch;
    tag_t [`DP_WIDTH-1:0]             dp_tag, dp_tag_old;
    logic [`DP_WIDTH-1:0]             dp_br, dp_mp;
    logic [`DP_WIDTH-1:0]             dp_ready;
    logic [`RT_WIDTH-1:0]             rt_valid;
    arch_idx_t [`RT_WIDTH-1:0]        rt_arch;
    tag_t [`RT_WIDTH-1:0]             rt_tag, rt_tag_old;
    logic                             flush;
    arch_idx_t                        amt_rd_arch;
    tag_t                             amt_rd_tag;

    instr_t      model_q [$];           // Accepted, not yet retired, oldest first
    tag_t        model_map [`ARCH_REG_NUM];
    logic [31:0] lfsr_q;
    tag_t        next_tag;
    string       test_name;
    int          err_cnt, retired_cnt, flush_cnt, test_cnt, cycle_cnt;
    int          err_at_start, ret_at_start;

    rename_core_top DUT (
        .clk_i           (clk),
        .reset_i         (reset),
        .dp_valid_i      (dp_valid),
        .dp_unit_i       (dp_unit),
        .dp_arch_reg_i   (dp_arch),
        .dp_tag_i        (dp_tag),
        .dp_tag_old_i    (dp_tag_old),
        .dp_is_branch_i  (dp_br),
        .dp_mispredict_i (dp_mp),
        .dp_ready_o      (dp_ready),
        .rt_valid_o      (rt_valid),
        .rt_arch_reg_o   (rt_arch),
        .rt_tag_o        (rt_tag),
        .rt_tag_old_o    (rt_tag_old),
        .flush_o         (flush),
        .amt_rd_arch_i   (amt_rd_arch),
        .amt_rd_tag_o    (amt_rd_tag)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;          // 8 ns period
    end

    ////////////////////
    // Helpers
    ////////////////////
    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);     // One step per bit
            r      = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    // Reference: oldest instruction retires next and writes the map
    function automatic logic ref_retire(output instr_t ins);
        ins = model_q.pop_front();
        model_map[ins.arch] = ins.tag;      // Slot order, so younger lands last
        return ins.is_branch && ins.mispredict;
    endfunction

    task automatic report_err(input string what, input int exp, input int act);
        err_cnt++;
        $display("ERR %s %s expected %0h actual %0h", test_name, what, exp, act);
    endtask

    task automatic start_test(input string name);
        test_name    = name;
        err_at_start = err_cnt;
        ret_at_start = retired_cnt;
    endtask

    task automatic end_test();
        test_cnt++;
        $display("Test %-10s retired %0d errors %0d", test_name,
                 retired_cnt - ret_at_start, err_cnt - err_at_start);
    endtask

    // Called just after a falling edge, ready is stable for the cycle
    task automatic drive_now(input logic [1:0] vld, input logic slow0,
                             input logic [1:0] br, input logic [1:0] mp,
                             input logic same_reg);
        logic [1:0] exp_rdy;
        int         avail;
        instr_t     ins;
        avail   = `ROB_ENTRY_NUM - model_q.size();
        exp_rdy = flush ? 2'b00 : (avail >= 2) ? 2'b11 : (avail == 1) ? 2'b01 : 2'b00;
        if (dp_ready !== exp_rdy) report_err("dp_ready", exp_rdy, dp_ready);
        for (int s = 0; s < `DP_WIDTH; s++) begin
            dp_valid[s]   = vld[s];
            dp_unit[s]    = ((s == 0) == slow0) ? EU_SLOW : EU_FAST;  // Slots differ
            dp_arch[s]    = (same_reg && s == 1) ? dp_arch[0] : arch_idx_t'(rand_bits(5));
            dp_tag[s]     = next_tag;
            next_tag      = next_tag + 1'b1;
            dp_tag_old[s] = tag_t'(rand_bits(6));
            dp_br[s]      = br[s];
            dp_mp[s]      = br[s] & mp[s];
            if (vld[s] && dp_ready[s]) begin
                ins = '{dp_arch[s], dp_tag[s], dp_tag_old[s], dp_br[s], dp_mp[s]};
                model_q.push_back(ins);
            end
        end
    endtask

    task automatic drain();
        @(negedge clk);
        drive_now(2'b00, 1'b0, 2'b00, 2'b00, 1'b0);
        while (model_q.size() != 0) begin
            @(negedge clk);
            drive_now(2'b00, 1'b0, 2'b00, 2'b00, 1'b0);
        end
        repeat (2) @(negedge clk);      // Map write lands after the last retire
    endtask

    task automatic check_map();
        for (int r = 0; r < `ARCH_REG_NUM; r++) begin
            @(negedge clk);
            amt_rd_arch = arch_idx_t'(r);
            #2;
            if (amt_rd_tag !== model_map[r]) begin
                report_err($sformatf("map r%0d", r), model_map[r], amt_rd_tag);
            end
        end
    endtask

    ////////////////////
    // Retire compare
    ////////////////////
    always @(posedge clk) begin : compare_retire
        instr_t exp_ins;
        logic   exp_flush;
        logic   stop;
        if (!reset) begin
            exp_flush = 1'b0;
            stop      = 1'b0;
            for (int s = 0; s < `RT_WIDTH; s++) begin
                if (rt_valid[s] && (stop || model_q.size() == 0)) begin
                    err_cnt++;
                    $display("Test %s: slot %0d retired an instruction out of order",
                             test_name, s);
                end else if (rt_valid[s]) begin
                    exp_flush = ref_retire(exp_ins);
                    stop      = exp_flush;      // Nothing younger in this group
                    retired_cnt++;
                    if (rt_arch[s] !== exp_ins.arch) report_err("arch", exp_ins.arch, rt_arch[s]);
                    if (rt_tag[s] !== exp_ins.tag) report_err("tag", exp_ins.tag, rt_tag[s]);
                    if (rt_tag_old[s] !== exp_ins.tag_old) begin
                        report_err("tag_old", exp_ins.tag_old, rt_tag_old[s]);
                    end
                end else begin
                    stop = 1'b1;
                end
            end
            if (flush !== exp_flush) report_err("flush", exp_flush, flush);
            if (flush === 1'b1) flush_cnt++;    // Flushes raised by the DUT
            if (exp_flush) begin
                model_q.delete();               // Younger work is squashed
            end
        end
    end

    initial begin : watchdog
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout after %0d cycles, the tests did not finish", CYCLE_LIMIT);
        $display("Something failed");
        $finish;
    end

    ////////////////////
    // Tests
    ////////////////////
    initial begin : main
        int         occ;
        int         n;
        int         flushes_before;
        logic       seen_01, seen_00;
        logic [1:0] vld;
        lfsr_q      = 32'h1cd4567e;
        next_tag    = '0;
        err_cnt     = 0;
        retired_cnt = 0;
        flush_cnt   = 0;
        test_cnt    = 0;
        test_name   = "reset";
        reset       = 1'b1;
        dp_valid    = '0;
        dp_unit     = {EU_SLOW, EU_FAST};
        dp_arch     = '0;
        dp_tag      = '0;
        dp_tag_old  = '0;
        dp_br       = '0;
        dp_mp       = '0;
        amt_rd_arch = '0;
        for (int r = 0; r < `ARCH_REG_NUM; r++) model_map[r] = tag_t'(r);   // Identity
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // 1: State after reset
        start_test("reset");
        @(negedge clk);
        if (dp_ready !== 2'b11) report_err("dp_ready", 2'b11, dp_ready);
        if (rt_valid !== 2'b00) report_err("rt_valid", 2'b00, rt_valid);
        if (flush !== 1'b0) report_err("flush", 1'b0, flush);
        check_map();
        end_test();

        // 2: Mixed units, no branches
        start_test("random");
        for (int c = 0; c < 120; c++) begin
            @(negedge clk);
            drive_now(2'(rand_bits(2)), rand_bits(1), 2'b00, 2'b00, 1'b0);
        end
        drain();
        check_map();
        end_test();

        // 3: Fill the buffer, the CDB is the bottleneck
        start_test("full");
        seen_01 = 1'b0;
        seen_00 = 1'b0;
        n       = 0;
        while (!(seen_01 && seen_00) && n < FILL_LIMIT) begin
            @(negedge clk);
            occ = model_q.size();
            if (occ == 15 && dp_ready === 2'b01) seen_01 = 1'b1;
            if (occ == 16 && dp_ready === 2'b00) seen_00 = 1'b1;
            vld = (!seen_01 && occ == 14) ? 2'b01 : 2'b11;  // Aim for 15 first
            drive_now(vld, vld == 2'b01, 2'b00, 2'b00, 1'b0);
            n++;
        end
        if (!(seen_01 && seen_00)) begin
            err_cnt++;
            $display("Test full: buffer never reached 15 and 16 entries");
        end
        for (int c = 0; c < 20; c++) begin     // Dispatch resumes as entries leave
            @(negedge clk);
            drive_now(2'b11, 1'b0, 2'b00, 2'b00, 1'b0);
        end
        drain();
        check_map();
        end_test();

        // 4: One mispredicted branch, then normal traffic
        start_test("mispredict");
        flushes_before = flush_cnt;
        for (int c = 0; c < 10; c++) begin
            @(negedge clk);
            if (c == 3) begin
                drive_now(2'b01, rand_bits(1), 2'b01, 2'b01, 1'b0);   // Bad branch
            end else begin
                drive_now(2'(rand_bits(2)), rand_bits(1),
                          {rand_bits(3) == 0, rand_bits(3) == 0}, 2'b00, 1'b0);
            end
        end
        drain();
        if (flush_cnt != flushes_before + 1) begin
            err_cnt++;
            $display("Test mispredict: expected one flush, saw %0d", flush_cnt - flushes_before);
        end
        for (int c = 0; c < 30; c++) begin
            @(negedge clk);
            drive_now(2'(rand_bits(2)), rand_bits(1), 2'b00, 2'b00, 1'b0);
        end
        drain();
        if (flush_cnt != flushes_before + 1) begin
            err_cnt++;
            $display("Test mispredict: flush seen without a mispredicted branch");
        end
        check_map();
        end_test();

        // 5: Both slots write one register, younger tag must stick
        start_test("same_reg");
        for (int c = 0; c < 20; c++) begin
            @(negedge clk);
            drive_now(2'b11, rand_bits(1), 2'b00, 2'b00, 1'b1);
        end
        drain();
        check_map();
        end_test();

        $display("Done: %0d tests, %0d retired, %0d flushes, %0d errors",
                 test_cnt, retired_cnt, flush_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
